/* hw/cpu_pkg.sv */
package cpu_pkg;

	// ****************************************
	// Opcodes and ALU operations
	// ****************************************
	localparam logic [5:0] op_alu  = 6'b000000;  // Zero word is add r0,r0,r0
	localparam logic [5:0] op_addi = 6'b101000;
	localparam logic [5:0] op_ori  = 6'b101100;
	localparam logic [5:0] op_movi = 6'b100010;
	localparam logic [5:0] op_lwi  = 6'b000010;
	localparam logic [5:0] op_swi  = 6'b001010;
	localparam logic [5:0] op_j    = 6'b100100;

	localparam logic [4:0] alu_add = 5'b00000;
	localparam logic [4:0] alu_sub = 5'b00001;
	localparam logic [4:0] alu_and = 5'b00010;
	localparam logic [4:0] alu_xor = 5'b00011;
	localparam logic [4:0] alu_or  = 5'b00100;
	localparam logic [4:0] alu_slt = 5'b00110;

	// Write-data source at the memory stage
	localparam logic [1:0] sel_alu = 2'd0;
	localparam logic [1:0] sel_mem = 2'd1;
	localparam logic [1:0] sel_imm = 2'd2;

	// ****************************************
	// Instruction word
	// ****************************************
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rt;
		logic [4:0] ra;
		logic [4:0] rb;
		logic [5:0] pad;
		logic [4:0] sub_op_base;
	} r_form_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rt;
		logic [4:0]  ra;
		logic [1:0]  pad;
		logic [13:0] imm14;
	} i_form_t;

	typedef union packed {
		r_form_t r_form;
		i_form_t i_form;
	} instr_t;

	// ****************************************
	// Stage bundles
	// ****************************************
	typedef struct packed {
		logic       do_dm_read;
		logic       do_dm_write;
		logic       do_reg_write;
		logic [1:0] select_write_reg;
	} ctrl_t;

	typedef struct packed {
		logic [31:0] ra_data;
		logic [31:0] alu_src2;
		logic [31:0] rt_data;
		logic [31:0] imm_extend;
		logic [4:0]  alu_op;
		logic [4:0]  write_reg_addr;
		ctrl_t       ctrl;
	} idex_t;

	typedef struct packed {
		logic [31:0] alu_result;
		logic [31:0] rt_data;
		logic [31:0] imm_extend;
		logic [4:0]  write_reg_addr;
		ctrl_t       ctrl;
	} exmem_t;

	typedef struct packed {
		logic        do_reg_write;
		logic [4:0]  write_reg_addr;
		logic [31:0] write_reg_data;
	} wb_t;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic        do_dm_read;
		logic        do_dm_write;
	} dmem_req_t;

	typedef struct packed {
		logic       use_ra;
		logic       use_r2;
		logic [4:0] ra_addr;
		logic [4:0] r2_addr;
	} src_use_t;

endpackage

/* hw/regwalls.sv */
`timescale 1ns/1ps

module regwalls (
	input  logic              clock,
	input  logic              rst_n,
	input  cpu_pkg::instr_t   imem_data,
	output cpu_pkg::instr_t   if_id,
	input  cpu_pkg::idex_t    idex_in,
	output cpu_pkg::idex_t    id_ex,
	input  logic [31:0]       alu_result,
	output cpu_pkg::exmem_t   ex_mem,
	input  logic [31:0]       dmem_rdata,
	output cpu_pkg::wb_t      mem_wb,
	input  logic              do_flush,
	input  logic              do_hazard
);

	logic [31:0] wb_data;

	// Write data picked on entry to mem_wb
	always_comb begin
		case (ex_mem.ctrl.select_write_reg)
			cpu_pkg::sel_mem: wb_data = dmem_rdata;
			cpu_pkg::sel_imm: wb_data = ex_mem.imm_extend;
			default:          wb_data = ex_mem.alu_result;
		endcase
	end

	// ****************************************
	// Fetch/decode
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			if_id <= '0;
		end else if (do_flush) begin
			if_id <= '0;  // Kill the word behind a jump
		end else if (!do_hazard) begin
			if_id <= imem_data;
		end
	end

	// Decode/execute takes a bubble on hazard
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			id_ex <= '0;
		end else if (do_hazard) begin
			id_ex <= '0;
		end else begin
			id_ex <= idex_in;
		end
	end

	// ****************************************
	// Execute/memory and memory/writeback
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			ex_mem <= '0;
			mem_wb <= '0;
		end else begin
			ex_mem.alu_result     <= alu_result;
			ex_mem.rt_data        <= id_ex.rt_data;
			ex_mem.imm_extend     <= id_ex.imm_extend;
			ex_mem.write_reg_addr <= id_ex.write_reg_addr;
			ex_mem.ctrl           <= id_ex.ctrl;

			mem_wb.do_reg_write   <= ex_mem.ctrl.do_reg_write;
			mem_wb.write_reg_addr <= ex_mem.write_reg_addr;
			mem_wb.write_reg_data <= wb_data;
		end
	end

endmodule

/* hw/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
	input  logic        clock,
	input  logic        rst_n,
	input  logic        do_hazard,
	input  logic        do_jump,
	input  logic [31:0] jump_target,
	output logic [31:0] pc
);

	// Word-addressed program counter
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (do_jump) begin
			pc <= jump_target;
		end else if (!do_hazard) begin
			pc <= pc + 32'd1;
		end
	end

endmodule

/* hw/decoder.sv */
`timescale 1ns/1ps

module decoder (
	input  cpu_pkg::instr_t   if_id,
	input  logic [31:0]       pc,
	output logic [4:0]        ra_addr,
	output logic [4:0]        r2_addr,
	input  logic [31:0]       ra_data,
	input  logic [31:0]       r2_data,
	output cpu_pkg::src_use_t src_use,
	output cpu_pkg::idex_t    idex_out,
	output logic              do_jump,
	output logic [31:0]       jump_target
);

	logic [5:0]     opcode;
	logic [31:0]    imm_ext;
	logic           src2_imm;
	logic           use_ra;
	logic           use_r2;
	logic [4:0]     alu_op;
	cpu_pkg::ctrl_t ctrl;

	assign opcode  = if_id.r_form.opcode;
	assign ra_addr = if_id.r_form.ra;
	assign r2_addr = (opcode == cpu_pkg::op_swi) ? if_id.i_form.rt : if_id.r_form.rb;

	// ori zero-extends, everything else sign-extends
	assign imm_ext = (opcode == cpu_pkg::op_ori) ? {18'b0, if_id.i_form.imm14}
	                                              : {{18{if_id.i_form.imm14[13]}}, if_id.i_form.imm14};

	// 26-bit target spans rt, ra, pad and imm14
	assign jump_target = {pc[31:26], if_id.i_form.rt, if_id.i_form.ra,
	                      if_id.i_form.pad, if_id.i_form.imm14};

	always_comb begin
		ctrl     = '0;
		alu_op   = cpu_pkg::alu_add;
		src2_imm = 1'b1;
		use_ra   = 1'b0;
		use_r2   = 1'b0;
		do_jump  = 1'b0;
		case (opcode)
			cpu_pkg::op_alu: begin
				alu_op            = if_id.r_form.sub_op_base;
				src2_imm          = 1'b0;
				use_ra            = 1'b1;
				use_r2            = 1'b1;
				ctrl.do_reg_write = 1'b1;
			end
			cpu_pkg::op_addi, cpu_pkg::op_ori: begin
				alu_op            = (opcode == cpu_pkg::op_ori) ? cpu_pkg::alu_or : cpu_pkg::alu_add;
				use_ra            = 1'b1;
				ctrl.do_reg_write = 1'b1;
			end
			cpu_pkg::op_movi: begin
				ctrl.do_reg_write     = 1'b1;
				ctrl.select_write_reg = cpu_pkg::sel_imm;
			end
			cpu_pkg::op_lwi: begin
				use_ra                = 1'b1;
				ctrl.do_dm_read       = 1'b1;
				ctrl.do_reg_write     = 1'b1;
				ctrl.select_write_reg = cpu_pkg::sel_mem;
			end
			cpu_pkg::op_swi: begin
				use_ra           = 1'b1;
				use_r2           = 1'b1;  // Store data from rt
				ctrl.do_dm_write = 1'b1;
			end
			cpu_pkg::op_j:   do_jump = 1'b1;
			default: ;
		endcase
	end

	assign src_use.use_ra  = use_ra;
	assign src_use.use_r2  = use_r2;
	assign src_use.ra_addr = ra_addr;
	assign src_use.r2_addr = r2_addr;

	assign idex_out.ra_data        = ra_data;
	assign idex_out.alu_src2       = src2_imm ? imm_ext : r2_data;
	assign idex_out.rt_data        = r2_data;
	assign idex_out.imm_extend     = imm_ext;
	assign idex_out.alu_op         = alu_op;
	assign idex_out.write_reg_addr = if_id.i_form.rt;
	assign idex_out.ctrl           = ctrl;

endmodule

/* hw/regfile.sv */
`timescale 1ns/1ps

module regfile (
	input  logic         clock,
	input  logic         rst_n,
	input  logic [4:0]   ra_addr,
	input  logic [4:0]   r2_addr,
	output logic [31:0]  ra_data,
	output logic [31:0]  r2_data,
	input  cpu_pkg::wb_t wr
);

	logic [31:0] regs [32];

	// r0 reads zero, same-cycle write passes through
	function automatic logic [31:0] read_port(input logic [4:0] addr);
		if (addr == 5'd0)
			return 32'd0;
		if (wr.do_reg_write && wr.write_reg_addr == addr)
			return wr.write_reg_data;
		return regs[addr];
	endfunction

	assign ra_data = read_port(ra_addr);
	assign r2_data = read_port(r2_addr);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wr.do_reg_write && wr.write_reg_addr != 5'd0) begin
			regs[wr.write_reg_addr] <= wr.write_reg_data;
		end
	end

endmodule

/* hw/alu.sv */
`timescale 1ns/1ps

module alu (
	input  cpu_pkg::idex_t id_ex,
	output logic [31:0]    alu_result
);

	logic [31:0] a;
	logic [31:0] b;

	assign a = id_ex.ra_data;
	assign b = id_ex.alu_src2;

	always_comb begin
		case (id_ex.alu_op)
			cpu_pkg::alu_add: alu_result = a + b;
			cpu_pkg::alu_sub: alu_result = a - b;
			cpu_pkg::alu_and: alu_result = a & b;
			cpu_pkg::alu_or:  alu_result = a | b;
			cpu_pkg::alu_xor: alu_result = a ^ b;
			cpu_pkg::alu_slt: alu_result = {31'd0, $signed(a) < $signed(b)};  // Signed compare
			default:          alu_result = '0;
		endcase
	end

endmodule

/* hw/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
	input  cpu_pkg::src_use_t src_use,
	input  cpu_pkg::idex_t    id_ex,
	input  cpu_pkg::exmem_t   ex_mem,
	output logic              do_hazard
);

	// Used nonzero source against one writer in flight
	function automatic logic dep(input logic used, input logic [4:0] src,
	                             input logic wr_en, input logic [4:0] dst);
		return used && src != 5'd0 && wr_en && src == dst;
	endfunction

	// mem_wb is covered by the regfile bypass
	assign do_hazard =
		dep(src_use.use_ra, src_use.ra_addr, id_ex.ctrl.do_reg_write, id_ex.write_reg_addr) ||
		dep(src_use.use_r2, src_use.r2_addr, id_ex.ctrl.do_reg_write, id_ex.write_reg_addr) ||
		dep(src_use.use_ra, src_use.ra_addr, ex_mem.ctrl.do_reg_write, ex_mem.write_reg_addr) ||
		dep(src_use.use_r2, src_use.r2_addr, ex_mem.ctrl.do_reg_write, ex_mem.write_reg_addr);

endmodule

/* hw/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core (
	input  logic               clock,
	input  logic               rst_n,
	output logic [31:0]        imem_addr,
	input  cpu_pkg::instr_t    imem_data,
	output cpu_pkg::dmem_req_t dmem,
	input  logic [31:0]        dmem_rdata,
	output cpu_pkg::wb_t       wb
);

	logic [31:0]       pc;
	logic              do_hazard;
	logic              do_jump;
	logic [31:0]       jump_target;
	logic [4:0]        ra_addr;
	logic [4:0]        r2_addr;
	logic [31:0]       ra_data;
	logic [31:0]       r2_data;
	logic [31:0]       alu_result;
	cpu_pkg::instr_t   if_id;
	cpu_pkg::idex_t    idex_in;
	cpu_pkg::idex_t    id_ex;
	cpu_pkg::exmem_t   ex_mem;
	cpu_pkg::wb_t      mem_wb;
	cpu_pkg::src_use_t src_use;

	// ****************************************
	// Stages
	fetch_unit u_fetch (
		.clock       (clock),
		.rst_n       (rst_n),
		.do_hazard   (do_hazard),
		.do_jump     (do_jump),
		.jump_target (jump_target),
		.pc          (pc)
	);

	regwalls u_walls (
		.clock      (clock),
		.rst_n      (rst_n),
		.imem_data  (imem_data),
		.if_id      (if_id),
		.idex_in    (idex_in),
		.id_ex      (id_ex),
		.alu_result (alu_result),
		.ex_mem     (ex_mem),
		.dmem_rdata (dmem_rdata),
		.mem_wb     (mem_wb),
		.do_flush   (do_jump),
		.do_hazard  (do_hazard)
	);

	decoder u_dec (
		.if_id       (if_id),
		.pc          (pc),
		.ra_addr     (ra_addr),
		.r2_addr     (r2_addr),
		.ra_data     (ra_data),
		.r2_data     (r2_data),
		.src_use     (src_use),
		.idex_out    (idex_in),
		.do_jump     (do_jump),
		.jump_target (jump_target)
	);

	regfile u_rf (
		.clock   (clock),
		.rst_n   (rst_n),
		.ra_addr (ra_addr),
		.r2_addr (r2_addr),
		.ra_data (ra_data),
		.r2_data (r2_data),
		.wr      (mem_wb)
	);

	hazard_unit u_haz (
		.src_use   (src_use),
		.id_ex     (id_ex),
		.ex_mem    (ex_mem),
		.do_hazard (do_hazard)
	);

	alu u_alu (
		.id_ex      (id_ex),
		.alu_result (alu_result)
	);

	// ****************************************
	// Memory and retire ports
	assign imem_addr        = pc;
	assign dmem.addr        = ex_mem.alu_result;  // Base plus immediate
	assign dmem.wdata       = ex_mem.rt_data;
	assign dmem.do_dm_read  = ex_mem.ctrl.do_dm_read;
	assign dmem.do_dm_write = ex_mem.ctrl.do_dm_write;
	assign wb               = mem_wb;

endmodule

/* tests/regwalls_assertions.sv */
`timescale 1ns/1ps

module regwalls_assertions (
	input logic            clock,
	input logic            rst_n,
	input cpu_pkg::instr_t if_id,
	input cpu_pkg::idex_t  id_ex,
	input cpu_pkg::exmem_t ex_mem,
	input cpu_pkg::wb_t    mem_wb,
	input logic            do_hazard
);

	// No control bit survives reset
	ctrl_clear_after_reset: assert property (@(posedge clock)
		$rose(rst_n) |-> (id_ex.ctrl == '0 && ex_mem.ctrl == '0 && !mem_wb.do_reg_write))
		else $error("Pipeline control set when reset was released");

	if_id_holds_on_hazard: assert property (@(posedge clock) disable iff (!rst_n)
		do_hazard |=> $stable(if_id))
		else $error("if_id changed across a hazard cycle");

	bubble_after_hazard: assert property (@(posedge clock) disable iff (!rst_n)
		do_hazard |=> (id_ex.ctrl == '0))  // Bubble carries no control
		else $error("id_ex control not cleared after a hazard cycle");

endmodule

bind regwalls regwalls_assertions u_walls_checks (
	.clock     (clock),
	.rst_n     (rst_n),
	.if_id     (if_id),
	.id_ex     (id_ex),
	.ex_mem    (ex_mem),
	.mem_wb    (mem_wb),
	.do_hazard (do_hazard)
);

/* tests/cpu_core_tb.sv */
`timescale 1ns/1ps

module cpu_core_tb;

	localparam int reset_cycles = 8;
	localparam int drain_cycles = 8;

	logic               clock;
	logic               rst_n;
	logic [31:0]        imem_addr;
	cpu_pkg::instr_t    imem_data;
	cpu_pkg::dmem_req_t dmem;
	logic [31:0]        dmem_rdata;
	cpu_pkg::wb_t       wb;

	cpu_pkg::instr_t    imem [256];
	logic [31:0]        dmem_mem [64];
	logic [31:0]        dmem_init [64];
	cpu_pkg::instr_t    prog [$];
	cpu_pkg::wb_t       exp_wb [$];
	cpu_pkg::dmem_req_t exp_st [$];
	int                 seed;
	int                 wb_idx;
	int                 st_idx;
	logic               tables_ready;

	cpu_core UUT (
		.clock      (clock),
		.rst_n      (rst_n),
		.imem_addr  (imem_addr),
		.imem_data  (imem_data),
		.dmem       (dmem),
		.dmem_rdata (dmem_rdata),
		.wb         (wb)
	);

	// ****************************************
	// Memory models with combinational reads
	assign imem_data  = (imem_addr < 32'd256) ? imem[imem_addr[7:0]] : '0;
	assign dmem_rdata = dmem_mem[dmem.addr[5:0]];

	always @(posedge clock) begin
		if (dmem.do_dm_write)
			dmem_mem[dmem.addr[5:0]] <= dmem.wdata;  // One-cycle store strobe
	end

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// ****************************************
	// Encoding and table helpers
	function automatic cpu_pkg::instr_t i_form_word(input logic [5:0] op, input logic [4:0] rt,
	                                                input logic [4:0] ra, input logic [13:0] imm);
		cpu_pkg::instr_t w;
		w = '0;
		w.i_form.opcode = op;
		w.i_form.rt     = rt;
		w.i_form.ra     = ra;
		w.i_form.imm14  = imm;
		return w;
	endfunction

	function automatic cpu_pkg::instr_t r_form_word(input logic [4:0] sub_op, input logic [4:0] rt,
	                                                input logic [4:0] ra, input logic [4:0] rb);
		cpu_pkg::instr_t w;
		w = '0;
		w.r_form.opcode      = cpu_pkg::op_alu;
		w.r_form.rt          = rt;
		w.r_form.ra          = ra;
		w.r_form.rb          = rb;
		w.r_form.sub_op_base = sub_op;
		return w;
	endfunction

	function automatic cpu_pkg::instr_t jump_word(input logic [25:0] target);
		return {cpu_pkg::op_j, target};
	endfunction

	task automatic expect_retire(input logic [4:0] rd, input logic [31:0] data);
		cpu_pkg::wb_t r;
		r.do_reg_write   = 1'b1;
		r.write_reg_addr = rd;
		r.write_reg_data = data;
		exp_wb.push_back(r);
	endtask

	task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
		cpu_pkg::dmem_req_t s;
		s.addr        = addr;
		s.wdata       = data;
		s.do_dm_read  = 1'b0;
		s.do_dm_write = 1'b1;
		exp_st.push_back(s);
	endtask

	// Program next to the results it must produce
	task automatic build_tables();
		prog.push_back(i_form_word(cpu_pkg::op_addi, 5'd1, 5'd0, 14'h3ffd));
		expect_retire(5'd1, 32'hffff_fffd);  // Sign-extended -3
		prog.push_back(i_form_word(cpu_pkg::op_ori, 5'd2, 5'd0, 14'h2abc));
		expect_retire(5'd2, 32'h0000_2abc);  // Zero-extended
		prog.push_back(i_form_word(cpu_pkg::op_movi, 5'd3, 5'd0, 14'h2000));
		expect_retire(5'd3, 32'hffff_e000);
		// Chain of R-form operations each on the previous result
		prog.push_back(r_form_word(cpu_pkg::alu_add, 5'd4, 5'd1, 5'd2));
		expect_retire(5'd4, 32'h0000_2ab9);
		prog.push_back(r_form_word(cpu_pkg::alu_sub, 5'd5, 5'd4, 5'd1));
		expect_retire(5'd5, 32'h0000_2abc);
		prog.push_back(r_form_word(cpu_pkg::alu_and, 5'd6, 5'd5, 5'd3));
		expect_retire(5'd6, 32'h0000_2000);
		prog.push_back(r_form_word(cpu_pkg::alu_or, 5'd7, 5'd6, 5'd1));
		expect_retire(5'd7, 32'hffff_fffd);
		prog.push_back(r_form_word(cpu_pkg::alu_xor, 5'd8, 5'd7, 5'd2));
		expect_retire(5'd8, 32'hffff_d541);
		prog.push_back(r_form_word(cpu_pkg::alu_slt, 5'd9, 5'd1, 5'd2));
		expect_retire(5'd9, 32'd1);  // -3 < 0x2abc when signed
		prog.push_back(r_form_word(cpu_pkg::alu_slt, 5'd10, 5'd2, 5'd1));
		expect_retire(5'd10, 32'd0);
		prog.push_back(i_form_word(cpu_pkg::op_addi, 5'd0, 5'd0, 14'd5));
		expect_retire(5'd0, 32'd5);
		prog.push_back(r_form_word(cpu_pkg::alu_add, 5'd11, 5'd0, 5'd2));
		expect_retire(5'd11, 32'h0000_2abc);  // r0 still reads zero
		// Memory
		prog.push_back(i_form_word(cpu_pkg::op_swi, 5'd11, 5'd0, 14'd10));
		expect_store(32'd10, 32'h0000_2abc);
		prog.push_back(i_form_word(cpu_pkg::op_lwi, 5'd12, 5'd0, 14'd10));
		expect_retire(5'd12, 32'h0000_2abc);
		prog.push_back(i_form_word(cpu_pkg::op_lwi, 5'd13, 5'd0, 14'd20));
		expect_retire(5'd13, dmem_init[20]);
		prog.push_back(i_form_word(cpu_pkg::op_addi, 5'd14, 5'd13, 14'd1));
		expect_retire(5'd14, dmem_init[20] + 32'd1);
		// Jump over two words where the first is fetched and killed
		prog.push_back(jump_word(26'd19));
		prog.push_back(i_form_word(cpu_pkg::op_swi, 5'd1, 5'd0, 14'd30));
		prog.push_back(i_form_word(cpu_pkg::op_addi, 5'd15, 5'd0, 14'd77));
		prog.push_back(i_form_word(cpu_pkg::op_addi, 5'd15, 5'd15, 14'd1));
		expect_retire(5'd15, 32'd1);
		prog.push_back(i_form_word(cpu_pkg::op_swi, 5'd15, 5'd1, 14'd24));
		expect_store(32'd21, 32'd1);  // Base -3 plus 24
		prog.push_back(i_form_word(cpu_pkg::op_lwi, 5'd16, 5'd1, 14'd24));
		expect_retire(5'd16, 32'd1);
		prog.push_back(r_form_word(cpu_pkg::alu_sub, 5'd17, 5'd0, 5'd16));
		expect_retire(5'd17, 32'hffff_ffff);
	endtask

	// ****************************************
	// Compare tasks
	task automatic abort_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic compare_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			abort_run($sformatf("ERR %s got=%h exp=%h", name, got, exp));
	endtask

	task automatic check_wb(input cpu_pkg::wb_t got, input cpu_pkg::wb_t exp);
		if (got !== exp)
			abort_run($sformatf("ERR wb got reg=%h data=%h exp reg=%h data=%h",
			                    got.write_reg_addr, got.write_reg_data,
			                    exp.write_reg_addr, exp.write_reg_data));
	endtask

	task automatic check_store(input cpu_pkg::dmem_req_t got, input cpu_pkg::dmem_req_t exp);
		if (got !== exp)
			abort_run($sformatf("ERR dmem got addr=%h wdata=%h rd=%h exp addr=%h wdata=%h rd=%h",
			                    got.addr, got.wdata, got.do_dm_read,
			                    exp.addr, exp.wdata, exp.do_dm_read));
	endtask

	task automatic check_idle();
		compare_word("wb.do_reg_write", 32'(wb.do_reg_write), 32'd0);
		compare_word("dmem.do_dm_write", 32'(dmem.do_dm_write), 32'd0);
	endtask

	// Nops and killed words retire as r0 <= 0 and are skipped
	task automatic sample_events();
		if (wb.do_reg_write && !(wb.write_reg_addr == 5'd0 && wb.write_reg_data == 32'd0)) begin
			if (wb_idx >= exp_wb.size()) begin
				abort_run($sformatf("Unexpected retire to r%0d after the program",
				                    wb.write_reg_addr));
			end else begin
				check_wb(wb, exp_wb[wb_idx]);
				wb_idx++;
			end
		end
		if (dmem.do_dm_write) begin
			if (st_idx >= exp_st.size()) begin
				abort_run($sformatf("Unexpected store to address %h", dmem.addr));
			end else begin
				check_store(dmem, exp_st[st_idx]);
				st_idx++;
			end
		end
	endtask

	// ****************************************
	// Main sequence
	initial begin
		logic [31:0] word;
		rst_n        = 1'b0;
		tables_ready = 1'b0;
		wb_idx       = 0;
		st_idx       = 0;
		seed         = 32'haf22;
		for (int i = 0; i < 64; i++) begin
			word         = $random(seed);
			dmem_init[i] = word;
			dmem_mem[i] <= word;
		end
		build_tables();
		foreach (imem[i])
			imem[i] = '0;
		foreach (prog[i])
			imem[i] = prog[i];
		tables_ready = 1'b1;

		repeat (reset_cycles) begin
			@(negedge clock);
			check_idle();
			compare_word("imem_addr", imem_addr, 32'd0);
		end
		rst_n = 1'b1;
		compare_word("imem_addr", imem_addr, 32'd0);
		@(negedge clock);
		check_idle();

		while (wb_idx < exp_wb.size() || st_idx < exp_st.size()) begin
			@(negedge clock);
			sample_events();
		end
		repeat (drain_cycles) begin
			@(negedge clock);
			sample_events();
		end

		$display(">>> PASS");
		$finish;
	end

	// Watchdog allows six cycles per program word plus reset
	initial begin
		wait (tables_ready);
		repeat (prog.size() * 6 + reset_cycles) @(posedge clock);
		abort_run("Timeout: retirement did not finish before the watchdog expired");
	end

endmodule

/* verilog.f */
hw/cpu_pkg.sv
hw/regwalls.sv
hw/fetch_unit.sv
hw/decoder.sv
hw/regfile.sv
hw/alu.sv
hw/hazard_unit.sv
hw/cpu_core.sv
tests/regwalls_assertions.sv
tests/cpu_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpu_core_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
